//--- logic/lbist_pkg.sv
`default_nettype none

package lbist_pkg;

    // ====================
    // Widths
    // ====================

    // Pattern count width
    localparam int COUNT_BITS = 16;

    // ====================
    // Controller states
    // ====================

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        CLEAR  = 3'd1,
        SEED   = 3'd2,
        RUN    = 3'd3,
        DRAIN1 = 3'd4,
        DRAIN2 = 3'd5,
        DONE   = 3'd6
    } ctrl_state_t;

    // ====================
    // Feedback taps
    // ====================

    // Tap positions per supported width, zero for anything else
    function automatic logic [31:0] tap_mask(input int width);
        logic [31:0] mask;
        mask = '0;
        case (width)
            8:  mask = (32'd1 << 3) | (32'd1 << 4) | (32'd1 << 5) | (32'd1 << 7);
            16: mask = (32'd1 << 10) | (32'd1 << 12) | (32'd1 << 13) | (32'd1 << 15);
            32: mask = (32'd1 << 24) | (32'd1 << 26) | (32'd1 << 29) | (32'd1 << 31);
            default: mask = '0;
        endcase
        return mask;
    endfunction

    // Four taps use inverted parity, two taps plain parity
    function automatic bit tap_is_xnor(input int width);
        logic [31:0] mask;
        int          taps;
        mask = tap_mask(width);
        taps = 0;
        for (int i = 0; i < 32; i++) begin
            if (mask[i]) begin
                taps++;
            end
        end
        return (taps == 4);
    endfunction

endpackage

`default_nettype wire

//--- logic/lfsr_pattern_gen.sv
`default_nettype none

module lfsr_pattern_gen #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             clear,

    // Seed request from the controller
    input  logic             req_val,
    input  logic [WIDTH-1:0] req_msg,
    output logic             req_rdy,

    // Pattern stream towards the CUT
    input  logic             resp_rdy,
    output logic             resp_val,
    output logic [WIDTH-1:0] resp_msg
);

    localparam logic [31:0]      TAP_FULL = lbist_pkg::tap_mask(WIDTH);
    localparam logic [WIDTH-1:0] TAPS     = TAP_FULL[WIDTH-1:0];
    localparam bit               USE_XNOR = lbist_pkg::tap_is_xnor(WIDTH);

    // Two-state control
    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_GEN  = 1'b1;

    if (TAP_FULL == '0) begin : g_bad_width
        $fatal(1, "lfsr_pattern_gen: unsupported WIDTH %0d", WIDTH);
    end

    logic             state_q;
    logic [WIDTH-1:0] lfsr_q;
    logic             parity;
    logic             feedback;
    logic             seed_fire;
    logic             shift_fire;

    // ====================
    // Feedback
    // ====================

    assign parity   = ^(lfsr_q & TAPS);
    assign feedback = USE_XNOR ? ~parity : parity;

    // ====================
    // Handshakes
    // ====================

    assign req_rdy  = (state_q == ST_IDLE);
    assign resp_val = (state_q == ST_GEN);
    assign resp_msg = lfsr_q;

    assign seed_fire  = req_val && req_rdy;
    assign shift_fire = resp_val && resp_rdy;

    // Clear drops back to idle and waits for a fresh seed
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            state_q <= ST_IDLE;
        end else if (seed_fire) begin
            state_q <= ST_GEN;
        end
    end

    // Shift register, first pattern out is the seed itself
    always_ff @(posedge clk) begin
        if (seed_fire) begin
            lfsr_q <= req_msg;
        end else if (shift_fire) begin
            lfsr_q <= {lfsr_q[WIDTH-2:0], feedback};
        end
    end

endmodule

`default_nettype wire

//--- logic/cut_datapath.sv
`default_nettype none

module cut_datapath #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             run,
    input  logic             fault_inject,

    // Pattern input
    input  logic             in_val,
    input  logic [WIDTH-1:0] in_data,
    output logic             in_rdy,

    // Registered response
    output logic             resp_val,
    output logic [WIDTH-1:0] resp_data
);

    localparam int HALF = WIDTH / 2;

    logic             accept;
    logic [HALF-1:0]  hi;
    logic [HALF-1:0]  lo;
    logic [HALF-1:0]  sum_half;
    logic [HALF-1:0]  mix_half;
    logic [WIDTH-1:0] result;

    // Only stall source is run low
    assign in_rdy = run;
    assign accept = in_val && in_rdy;

    assign hi = in_data[WIDTH-1:HALF];
    assign lo = in_data[HALF-1:0];

    // Sum wraps at half width
    assign sum_half = hi + lo;
    assign mix_half = hi ^ {lo[HALF-2:0], lo[HALF-1]};

    always_comb begin
        result = {sum_half, mix_half};
        // Stuck-at-one defect on the LSB
        if (fault_inject) begin
            result[0] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_val <= 1'b0;
        end else begin
            resp_val <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_data <= result;
        end
    end

endmodule

`default_nettype wire

//--- logic/misr_compactor.sv
`default_nettype none

module misr_compactor #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             clear,
    input  logic             in_val,
    input  logic [WIDTH-1:0] in_data,
    output logic [WIDTH-1:0] signature
);

    // Same polynomial as the pattern generator
    localparam logic [31:0]      TAP_FULL = lbist_pkg::tap_mask(WIDTH);
    localparam logic [WIDTH-1:0] TAPS     = TAP_FULL[WIDTH-1:0];
    localparam bit               USE_XNOR = lbist_pkg::tap_is_xnor(WIDTH);

    if (TAP_FULL == '0) begin : g_bad_width
        $fatal(1, "misr_compactor: unsupported WIDTH %0d", WIDTH);
    end

    logic             parity;
    logic             feedback;
    logic [WIDTH-1:0] next_sig;

    assign parity   = ^(signature & TAPS);
    assign feedback = USE_XNOR ? ~parity : parity;

    // Shift with feedback, then fold in the response word
    assign next_sig = {signature[WIDTH-2:0], feedback} ^ in_data;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            signature <= '0;
        end else if (in_val) begin
            signature <= next_sig;
        end
    end

endmodule

`default_nettype wire

//--- logic/lbist_controller.sv
`default_nettype none

module lbist_controller #(
    parameter int WIDTH = 16
) (
    input  logic                             clk,
    input  logic                             reset,

    // Test request
    input  logic                             start,
    input  logic [WIDTH-1:0]                 seed,
    input  logic [lbist_pkg::COUNT_BITS-1:0] pattern_count,
    input  logic [WIDTH-1:0]                 golden,
    input  logic [WIDTH-1:0]                 signature,

    // Status
    output logic                             busy,
    output logic                             done,
    output logic                             pass,

    // Engine control
    output logic                             clear,
    output logic                             seed_val,
    output logic [WIDTH-1:0]                 seed_msg,
    input  logic                             seed_rdy,
    output logic                             run
);

    lbist_pkg::ctrl_state_t state_q;
    lbist_pkg::ctrl_state_t next_state;

    logic [lbist_pkg::COUNT_BITS-1:0] count_q;
    logic [WIDTH-1:0]                 seed_q;
    logic [WIDTH-1:0]                 golden_q;
    logic                             pass_q;
    logic                             start_fire;
    logic                             seed_fire;
    logic                             last_pattern;

    // ====================
    // Decodes
    // ====================

    assign start_fire   = start && (state_q == lbist_pkg::IDLE);
    assign seed_fire    = seed_val && seed_rdy;
    assign last_pattern = (count_q == 1);

    assign busy     = (state_q != lbist_pkg::IDLE);
    assign done     = (state_q == lbist_pkg::DONE);
    assign clear    = (state_q == lbist_pkg::CLEAR);
    assign seed_val = (state_q == lbist_pkg::SEED);
    assign run      = (state_q == lbist_pkg::RUN);
    assign seed_msg = seed_q;
    assign pass     = pass_q;

    // ====================
    // Next state
    // ====================

    always_comb begin
        next_state = state_q;
        case (state_q)
            lbist_pkg::IDLE: begin
                if (start_fire) begin
                    next_state = lbist_pkg::CLEAR;
                end
            end
            lbist_pkg::CLEAR: begin
                next_state = lbist_pkg::SEED;
            end
            lbist_pkg::SEED: begin
                // Zero patterns goes straight to the drain
                if (seed_fire) begin
                    next_state = (count_q == '0) ? lbist_pkg::DRAIN1 : lbist_pkg::RUN;
                end
            end
            lbist_pkg::RUN: begin
                if (last_pattern) begin
                    next_state = lbist_pkg::DRAIN1;
                end
            end
            // CUT output then MISR update still in flight
            lbist_pkg::DRAIN1: next_state = lbist_pkg::DRAIN2;
            lbist_pkg::DRAIN2: next_state = lbist_pkg::DONE;
            lbist_pkg::DONE:   next_state = lbist_pkg::IDLE;
            default:           next_state = lbist_pkg::IDLE;
        endcase
    end

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= lbist_pkg::IDLE;
            count_q <= '0;
            pass_q  <= 1'b0;
        end else begin
            state_q <= next_state;
            if (start_fire) begin
                count_q <= pattern_count;
                pass_q  <= 1'b0;
            end else if (state_q == lbist_pkg::RUN) begin
                count_q <= count_q - 1'b1;
            end
            // Signature is final during the second drain cycle
            if (state_q == lbist_pkg::DRAIN2) begin
                pass_q <= (signature == golden_q);
            end
        end
    end

    // Request parameters held for the whole run
    always_ff @(posedge clk) begin
        if (start_fire) begin
            seed_q   <= seed;
            golden_q <= golden;
        end
    end

endmodule

`default_nettype wire

//--- logic/lbist_top.sv
`default_nettype none

module lbist_top #(
    parameter int WIDTH = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  logic [WIDTH-1:0]                 seed,
    input  logic [lbist_pkg::COUNT_BITS-1:0] pattern_count,
    input  logic [WIDTH-1:0]                 golden,
    input  logic                             fault_inject,
    output logic                             busy,
    output logic                             done,
    output logic                             pass,
    output logic [WIDTH-1:0]                 signature
);

    // Controller broadcasts
    logic             clear;
    logic             run;

    // Seed request
    logic             seed_val;
    logic [WIDTH-1:0] seed_msg;
    logic             seed_rdy;

    // Pattern stream
    logic             pat_val;
    logic [WIDTH-1:0] pat_msg;
    logic             pat_rdy;

    // CUT response
    logic             resp_val;
    logic [WIDTH-1:0] resp_data;

    lbist_controller #(
        .WIDTH(WIDTH)
    ) u_controller (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .seed         (seed),
        .pattern_count(pattern_count),
        .golden       (golden),
        .signature    (signature),
        .busy         (busy),
        .done         (done),
        .pass         (pass),
        .clear        (clear),
        .seed_val     (seed_val),
        .seed_msg     (seed_msg),
        .seed_rdy     (seed_rdy),
        .run          (run)
    );

    lfsr_pattern_gen #(
        .WIDTH(WIDTH)
    ) u_lfsr (
        .clk     (clk),
        .reset   (reset),
        .clear   (clear),
        .req_val (seed_val),
        .req_msg (seed_msg),
        .req_rdy (seed_rdy),
        .resp_rdy(pat_rdy),
        .resp_val(pat_val),
        .resp_msg(pat_msg)
    );

    cut_datapath #(
        .WIDTH(WIDTH)
    ) u_cut (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .fault_inject(fault_inject),
        .in_val      (pat_val),
        .in_data     (pat_msg),
        .in_rdy      (pat_rdy),
        .resp_val    (resp_val),
        .resp_data   (resp_data)
    );

    misr_compactor #(
        .WIDTH(WIDTH)
    ) u_misr (
        .clk      (clk),
        .reset    (reset),
        .clear    (clear),
        .in_val   (resp_val),
        .in_data  (resp_data),
        .signature(signature)
    );

endmodule

`default_nettype wire

//--- tests/lbist_props.sv
`default_nettype none

module lbist_props #(
    parameter int WIDTH = 16
) (
    input logic                             clk,
    input logic                             reset,
    input logic                             done,
    input logic                             run,
    input logic                             seed_rdy,
    input logic [WIDTH-1:0]                 signature,
    input logic [lbist_pkg::COUNT_BITS-1:0] count,
    input lbist_pkg::ctrl_state_t           state
);
    timeunit 1ns;
    timeprecision 1ps;

    int violations = 0;

    // Signature already settled when done rises
    a_done_single: assert property (@(posedge clk) disable iff (reset)
        done |-> $stable(signature) ##1 !done)
        else begin
            violations++;
            $error("done stayed high for a second cycle or signature moved under done");
        end

    // Run only while patterns remain
    a_run_with_patterns: assert property (@(posedge clk) disable iff (reset)
        run |-> (count != '0))
        else begin
            violations++;
            $error("run high with no patterns left");
        end

    // Seed load always follows the clear cycle, with the LFSR back in idle
    a_clear_then_seed: assert property (@(posedge clk) disable iff (reset)
        (state == lbist_pkg::CLEAR) |=> (state == lbist_pkg::SEED) && seed_rdy)
        else begin
            violations++;
            $error("state after CLEAR was not SEED with the LFSR ready");
        end

endmodule

bind lbist_controller lbist_props #(
    .WIDTH(WIDTH)
) u_props (
    .clk      (clk),
    .reset    (reset),
    .done     (done),
    .run      (run),
    .seed_rdy (seed_rdy),
    .signature(signature),
    .count    (count_q),
    .state    (state_q)
);

`default_nettype wire

//--- tests/lbist_checker.sv
`default_nettype none

module lbist_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic [15:0] seed,
    input  logic [15:0] pattern_count,
    input  logic [15:0] golden,
    input  logic        fault_inject,
    input  logic        busy,
    input  logic        done,
    input  logic        pass,
    input  logic [15:0] signature,
    output int          checks,
    output int          check_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    // Taps 15, 13, 12, 10 with XNOR feedback
    localparam logic [15:0] TAPS = 16'hB400;

    logic        pending = 1'b0;
    logic [15:0] exp_sig;
    logic [15:0] exp_golden;
    logic        exp_pass;
    int          exp_count;
    int          cycles;
    int          n_checks = 0;
    int          n_errors = 0;

    assign checks       = n_checks;
    assign check_errors = n_errors;

    // ====================
    // Reference model
    // ====================

    // Replays LFSR, CUT and MISR for one whole run
    function automatic logic [15:0] expected_signature(
        input logic [15:0] start_seed,
        input int          count,
        input bit          fault
    );
        logic [15:0] state;
        logic [15:0] sig;
        logic [15:0] resp;
        logic [7:0]  sum;
        state = start_seed;
        sig   = '0;
        for (int i = 0; i < count; i++) begin
            sum     = state[15:8] + state[7:0];
            resp    = {sum, state[15:8] ^ {state[6:0], state[7]}};
            resp[0] = resp[0] | fault;
            sig     = {sig[14:0], ~^(sig & TAPS)} ^ resp;
            state   = {state[14:0], ~^(state & TAPS)};
        end
        return sig;
    endfunction

    // ====================
    // Compare at done
    // ====================

    always @(posedge clk) begin
        if (reset) begin
            pending = 1'b0;
        end else if (pending) begin
            cycles++;
            if (done) begin
                pending = 1'b0;
                n_checks++;
                exp_pass = (exp_sig == exp_golden);
                if (signature !== exp_sig) begin
                    $display("FAIL signature: got 16'h%h expected 16'h%h", signature, exp_sig);
                    n_errors++;
                end
                if (pass !== exp_pass) begin
                    $display("FAIL pass: got 1'h%h expected 1'h%h", pass, exp_pass);
                    n_errors++;
                end
                // Done rises after edge N+4, seen here one edge later
                if (cycles != exp_count + 5) begin
                    $display("Done came %0d cycles after start instead of %0d",
                             cycles - 1, exp_count + 4);
                    n_errors++;
                end
            end else if (cycles > exp_count + 5) begin
                $display("No done pulse %0d cycles after start", cycles - 1);
                n_errors++;
                pending = 1'b0;
            end
        end else if (done) begin
            $display("Done pulse without an accepted start");
            n_errors++;
        end else if (start && !busy) begin
            exp_sig    = expected_signature(seed, int'(pattern_count), fault_inject);
            exp_golden = golden;
            exp_count  = int'(pattern_count);
            cycles     = 0;
            pending    = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- tests/lbist_tb.sv
`default_nettype none

module lbist_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WIDTH = 16;
    localparam int CB    = lbist_pkg::COUNT_BITS;

    logic             clk = 1'b0;
    logic             reset;
    logic             start;
    logic [WIDTH-1:0] seed;
    logic [CB-1:0]    pattern_count;
    logic [WIDTH-1:0] golden;
    logic             fault_inject;
    logic             busy;
    logic             done;
    logic             pass;
    logic [WIDTH-1:0] signature;
    int               checks;
    int               check_errors;

    int               tb_errors    = 0;
    int               tests_run    = 0;
    int               tests_failed = 0;
    int               errors_seen  = 0;
    int               n;
    logic [WIDTH-1:0] seed_r;
    logic [WIDTH-1:0] good_sig;

    always #10 clk = ~clk;

    lbist_top #(.WIDTH(WIDTH)) u_lbist_top (.*);
    lbist_checker u_checker (.*);

    // ====================
    // Helpers
    // ====================

    function automatic int error_total();
        return tb_errors + check_errors + u_lbist_top.u_controller.u_props.violations;
    endfunction

    task automatic start_run(input logic [WIDTH-1:0] s, input int cnt, input logic [WIDTH-1:0] g);
        @(negedge clk);
        seed          = s;
        pattern_count = CB'(cnt);
        golden        = g;
        start         = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // Bounded wait for done, then pass is read mid-cycle
    task automatic finish_run(input int cnt, input logic exp_pass);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < 200 + cnt && !seen; i++) begin
            @(posedge clk);
            seen = done;
        end
        @(negedge clk);
        if (seen && pass !== exp_pass) begin
            $display("FAIL pass: got 1'h%h expected 1'h%h", pass, exp_pass);
            tb_errors++;
        end
        if (!seen) begin
            $display("Timed out after %0d cycles waiting for done", 200 + cnt);
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_total() != errors_seen) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
        errors_seen = error_total();
    endtask

    // ====================
    // Stimulus
    // ====================

    initial begin
        n             = $urandom(32'hc67a_a361);
        reset         = 1'b1;
        start         = 1'b0;
        seed          = '0;
        pattern_count = '0;
        golden        = '0;
        fault_inject  = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        good_sig = u_checker.expected_signature(16'h0001, 8, 1'b0);
        start_run(16'h0001, 8, good_sig);
        finish_run(8, 1'b1);
        end_test("known_run");

        // Odd runs get a golden with one bit flipped
        for (int i = 0; i < 20; i++) begin
            seed_r   = WIDTH'($urandom);
            n        = $urandom_range(300, 1);
            good_sig = u_checker.expected_signature(seed_r, n, 1'b0);
            start_run(seed_r, n, (i % 2) ? good_sig ^ (16'h1 << ($urandom % WIDTH)) : good_sig);
            finish_run(n, (i % 2) == 0);
        end
        end_test("random_runs");

        seed_r   = WIDTH'($urandom);
        good_sig = u_checker.expected_signature(seed_r, 64, 1'b0);
        @(negedge clk);
        fault_inject = 1'b1;
        start_run(seed_r, 64, good_sig);
        finish_run(64, 1'b0);
        if (signature === good_sig) begin
            $display("FAIL signature: got 16'h%h, equal to the fault-free 16'h%h",
                     signature, good_sig);
            tb_errors++;
        end
        fault_inject = 1'b0;
        end_test("fault_injection");

        start_run(WIDTH'($urandom), 0, '0);
        finish_run(0, 1'b1);
        end_test("zero_count");

        // Second start lands while busy and must be dropped
        seed_r = WIDTH'($urandom);
        start_run(seed_r, 40, u_checker.expected_signature(seed_r, 40, 1'b0));
        repeat (5) @(negedge clk);
        start_run(~seed_r, 12, '0);
        finish_run(40, 1'b1);
        start_run(seed_r, 100, '0);
        repeat (20) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        if (busy !== 1'b0 || u_lbist_top.run !== 1'b0) begin
            $display("Reset in the middle of a run left busy or run high");
            tb_errors++;
        end
        reset  = 1'b0;
        seed_r = WIDTH'($urandom);
        start_run(seed_r, 30, u_checker.expected_signature(seed_r, 30, 1'b0));
        finish_run(30, 1'b1);
        end_test("busy_and_reset");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, error_total());
        if (error_total() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
logic/lbist_pkg.sv
logic/lfsr_pattern_gen.sv
logic/cut_datapath.sv
logic/misr_compactor.sv
logic/lbist_controller.sv
logic/lbist_top.sv
tests/lbist_props.sv
tests/lbist_checker.sv
tests/lbist_tb.sv
